// ==== project.f ====
rtl/tetris_pkg.sv
rtl/clear_if.sv
rtl/move_arbiter.sv
rtl/piece_engine.sv
rtl/line_clear.sv
rtl/tetris_top.sv
testbench/tetris_checker.sv
testbench/tb_tetris.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_tetris

all: run

$(SIM): project.f $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tetris -f project.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== testbench/tb_tetris.sv ====
`timescale 1ns/100ps

module tb_tetris;
  import tetris_pkg::*;

  logic clk;
  logic rst;
  logic en;
  logic right;
  logic left;
  logic down;
  logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] grid;
  logic ready;
  logic game_over;
  logic lock;
  logic [LINES_W-1:0] lines;

  // model: settled stack plus the falling piece
  int stack [ROWS][COLS];
  int m_row;
  int m_col;
  int m_shape;
  int m_next;
  int m_lines;
  bit m_active;
  bit m_over;
  bit exp_lock;
  bit lock_seen;

  string test_name;
  event  sample_ev;
  int    seed;

  tetris_top tetris_top_i (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .right     (right),
    .left      (left),
    .down      (down),
    .grid      (grid),
    .ready     (ready),
    .game_over (game_over),
    .lock      (lock),
    .lines     (lines)
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////
  // reference model
  ////////////////////

  // all set frame cells inside the grid and on empty stack cells
  function automatic bit fits_at(input int shape, input int r0, input int c0);
    logic [15:0] m;
    bit ok;
    m = SHAPE_MASKS[shape];
    ok = 1'b1;
    for (int fr = 0; fr < 4; fr++) begin
      for (int fc = 0; fc < 4; fc++) begin
        if (m[4*fr+fc]) begin
          if (r0 + fr >= ROWS || c0 + fc < 0 || c0 + fc >= COLS) begin
            ok = 1'b0;
          end else if (stack[r0+fr][c0+fc] != 0) begin
            ok = 1'b0;
          end
        end
      end
    end
    return ok;
  endfunction

  // drop full rows, shift the rest down, return how many went
  function automatic int clear_rows();
    int n;
    int w;
    bit full;
    n = 0;
    w = ROWS - 1;
    for (int r = ROWS - 1; r >= 0; r--) begin
      full = 1'b1;
      for (int c = 0; c < COLS; c++) begin
        if (stack[r][c] == 0) full = 1'b0;
      end
      if (full) begin
        n++;
      end else begin
        for (int c = 0; c < COLS; c++) stack[w][c] = stack[r][c];
        w--;
      end
    end
    for (int r = w; r >= 0; r--) begin
      for (int c = 0; c < COLS; c++) stack[r][c] = 0;
    end
    return n;
  endfunction

  // what the grid output should show
  function automatic logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] expected_grid();
    logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] g;
    logic [15:0] m;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) g[r][c] = CELL_W'(stack[r][c]);
    end
    if (m_active) begin
      m = SHAPE_MASKS[m_shape];
      for (int fr = 0; fr < 4; fr++) begin
        for (int fc = 0; fc < 4; fc++) begin
          if (m[4*fr+fc]) g[m_row+fr][m_col+fc] = CELL_W'(m_shape + 1);
        end
      end
    end
    return g;
  endfunction

  task automatic model_reset();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) stack[r][c] = 0;
    end
    m_lines  = 0;
    m_next   = 0;
    m_active = 1'b0;
    m_over   = 1'b0;
  endtask

  task automatic model_spawn();
    if (fits_at(m_next, SPAWN_ROW, SPAWN_COL)) begin
      m_shape  = m_next;
      m_row    = SPAWN_ROW;
      m_col    = SPAWN_COL;
      m_next   = (m_next + 1) % NUM_SHAPES;
      m_active = 1'b1;
    end else begin
      m_active = 1'b0;
      m_over   = 1'b1;
    end
  endtask

  // right over left over down, dropped unless a piece is falling
  task automatic model_move(input bit r, input bit l, input bit d);
    logic [15:0] m;
    int tr;
    int tc;
    exp_lock = 1'b0;
    tr = m_row;
    tc = m_col;
    if (r) tc++;
    else if (l) tc--;
    else if (d) tr++;
    if (m_active && (r || l || d)) begin
      if (fits_at(m_shape, tr, tc)) begin
        m_row = tr;
        m_col = tc;
      end else if (!r && !l) begin
        // blocked down settles the piece into the stack
        m = SHAPE_MASKS[m_shape];
        for (int fr = 0; fr < 4; fr++) begin
          for (int fc = 0; fc < 4; fc++) begin
            if (m[4*fr+fc]) stack[m_row+fr][m_col+fc] = m_shape + 1;
          end
        end
        m_active = 1'b0;
        exp_lock = 1'b1;
        m_lines  = m_lines + clear_rows();
        model_spawn();
      end
    end
  endtask

  ////////////////////
  // checks and waits
  ////////////////////

  task automatic check(input string name, input logic [ROWS*COLS*CELL_W-1:0] exp,
                       input logic [ROWS*COLS*CELL_W-1:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped on failure");
  endtask

  // play settled means ready or game_over, else both low
  task automatic wait_settled(input bit want_play);
    int n;
    bit hit;
    n = 0;
    hit = 1'b0;
    while (!hit && n < 100) begin
      @(negedge clk);
      n++;
      hit = want_play ? (ready || game_over) : (!ready && !game_over);
    end
    if (!hit) fail_plain({"timeout while waiting for the DUT to settle in ", test_name});
  endtask

  // one command: buttons high for one cycle, then released
  task automatic press(input bit r, input bit l, input bit d, input string name);
    @(negedge clk);
    right = r;
    left = l;
    down = d;
    test_name = name;
    model_move(r, l, d);
    @(negedge clk);
    right = 1'b0;
    left = 1'b0;
    down = 1'b0;
    // engine acted on the edge before this one
    @(negedge clk);
    lock_seen = lock;
    wait_settled(1'b1);
    -> sample_ev;
  endtask

  task automatic pulse_en(input string name);
    bit from_over;
    @(negedge clk);
    en = 1'b1;
    test_name = name;
    exp_lock = 1'b0;
    from_over = m_over;
    if (m_over) model_reset();
    else if (!m_active) model_spawn();
    @(negedge clk);
    en = 1'b0;
    wait_settled(!from_over);
    lock_seen = lock;
    -> sample_ev;
  endtask

  // compare process
  always begin
    @(sample_ev);
    check({test_name, " grid"}, expected_grid(), grid);
    check({test_name, " lines"}, m_lines, lines);
    check({test_name, " game_over"}, m_over, game_over);
    check({test_name, " ready"}, m_active, ready);
    check({test_name, " lock"}, exp_lock, lock_seen);
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : stimulus
    int n;
    int placed;
    int tgt;
    logic [31:0] rnd;
    clk = 1'b0;
    rst = 1'b1;
    en = 1'b0;
    right = 1'b0;
    left = 1'b0;
    down = 1'b0;
    seed = 32'h853b_f1f6;
    model_reset();
    exp_lock = 1'b0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    lock_seen = lock;
    -> sample_ev;
    pulse_en("start");

    // I piece from col 3 to the right wall and back to col 0
    repeat (4) press(1'b1, 1'b0, 1'b0, "right wall");
    repeat (8) press(1'b0, 1'b1, 1'b0, "left wall");
    press(1'b1, 1'b1, 1'b0, "right beats left");

    // drop to the floor, next down locks
    n = 0;
    while (!exp_lock && n < 30) begin
      press(1'b0, 1'b0, 1'b1, "drop and lock");
      n++;
    end
    if (!exp_lock) fail_plain("drop and lock: piece never locked");
    press(1'b0, 1'b0, 1'b1, "next shape");

    // straight drops at the spawn column until the stack tops out
    n = 0;
    while (!m_over && n < 600) begin
      press(1'b0, 1'b0, 1'b1, "game over");
      n++;
    end
    if (!m_over) fail_plain("game over: stack never reached the spawn position");
    press(1'b1, 1'b0, 1'b0, "moves after game over");
    press(1'b0, 1'b1, 1'b0, "moves after game over");
    press(1'b0, 1'b0, 1'b1, "moves after game over");
    pulse_en("restart clear");
    pulse_en("restart spawn");

    // random play, I and O close the bottom row on the eighth piece
    placed = 0;
    n = 0;
    while (m_lines == 0 && n < 400) begin
      if (m_shape == 1) tgt = 7;
      else if (m_shape == 0 && placed >= 7) tgt = 4;
      else tgt = 0;
      rnd = $random(seed);
      if (m_col != tgt && (rnd[0] || m_row >= 2)) begin
        press(m_col < tgt, m_col > tgt, 1'b0, "line clear");
      end else begin
        press(1'b0, 1'b0, 1'b1, "line clear");
      end
      if (exp_lock) placed++;
      n++;
    end
    if (m_lines == 0) fail_plain("line clear: no line cleared within the command limit");

    // top out again so restart meets a nonzero line count
    n = 0;
    while (!m_over && n < 600) begin
      press(1'b0, 1'b0, 1'b1, "restart lines");
      n++;
    end
    if (!m_over) fail_plain("restart lines: stack never reached the spawn position");
    pulse_en("restart lines");

    // let the last compare run
    @(negedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== testbench/tetris_checker.sv ====
`timescale 1ns/100ps

module tetris_checker (
  input logic clk,
  input logic rst,
  input logic ready,
  input logic game_over,
  input logic lock,
  input logic start,
  input logic done,
  input logic [tetris_pkg::ROWS-1:0][tetris_pkg::COLS-1:0][tetris_pkg::CELL_W-1:0] grid
);

  // a pass runs from start until done
  logic pass_run;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pass_run <= 1'b0;
    end else if (start) begin
      pass_run <= 1'b1;
    end else if (done) begin
      pass_run <= 1'b0;
    end
  end

  ////////////////////
  // protocol
  ////////////////////

  a_ready_over: assert property (@(posedge clk) disable iff (rst) !(ready && game_over))
    else $error("ready and game_over high together");

  a_lock_pulse: assert property (@(posedge clk) disable iff (rst) lock |=> !lock)
    else $error("lock longer than one cycle");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("clear done longer than one cycle");

  a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !pass_run)
    else $error("start given while a clear pass runs");

  // first edge after release
  a_grid_reset: assert property (@(posedge clk) $fell(rst) |-> (grid == '0))
    else $error("grid not empty after reset");

endmodule

bind tetris_top tetris_checker tetris_checker_i (
  .clk       (clk),
  .rst       (rst),
  .ready     (ready),
  .game_over (game_over),
  .lock      (lock),
  .start     (clear_bus.start),
  .done      (clear_bus.done),
  .grid      (grid)
);

// ==== rtl/tetris_top.sv ====
`timescale 1ns/100ps

module tetris_top (
  input  logic clk,
  input  logic rst,
  input  logic en,
  input  logic right,
  input  logic left,
  input  logic down,
  output logic [tetris_pkg::ROWS-1:0][tetris_pkg::COLS-1:0][tetris_pkg::CELL_W-1:0] grid,
  output logic ready,
  output logic game_over,
  output logic lock,
  output logic [tetris_pkg::LINES_W-1:0] lines
);

  ////////////////////
  // internal wiring
  ////////////////////

  // button stage to engine
  logic       move_valid;
  logic [1:0] move;

  // engine to line_clear hand-off
  clear_if clear_bus ();

  // edge detect and priority
  move_arbiter move_arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .right      (right),
    .left       (left),
    .down       (down),
    .move_valid (move_valid),
    .move       (move)
  );

  // game fsm and grid
  piece_engine piece_engine_i (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .move_valid (move_valid),
    .move       (move),
    .clr        (clear_bus.engine_mp),
    .grid       (grid),
    .ready      (ready),
    .game_over  (game_over),
    .lock       (lock)
  );

  // row compaction and line count
  line_clear line_clear_i (
    .clk   (clk),
    .rst   (rst),
    .clr   (clear_bus.clear_mp),
    .lines (lines)
  );

endmodule

// ==== rtl/line_clear.sv ====
`timescale 1ns/100ps

module line_clear (
  input  logic                        clk,
  input  logic                        rst,
  clear_if.clear_mp                   clr,
  output logic [tetris_pkg::LINES_W-1:0] lines
);
  import tetris_pkg::*;

  // pass phases
  logic walking;
  logic filling;
  logic busy;

  // read walks bottom to top, write trails behind it
  logic [ROW_W-1:0] rd_ptr;
  logic [ROW_W-1:0] wr_ptr;
  logic [ROW_W-1:0] cnt;
  logic             row_full;

  // captured and compacted grids
  logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] src;
  logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] dst;

  assign busy          = walking | filling;
  assign clr.grid_out  = dst;
  assign clr.full_rows = cnt;

  // row is full when no cell is empty
  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < COLS; c++) begin
      if (src[rd_ptr][c] == '0) begin
        row_full = 1'b0;
      end
    end
  end

  ////////////////////
  // pass control
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      walking  <= 1'b0;
      filling  <= 1'b0;
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      cnt      <= '0;
      lines    <= '0;
      clr.done <= 1'b0;
    end else begin
      clr.done <= 1'b0;
      if (clr.start && !busy) begin
        walking <= 1'b1;
        rd_ptr  <= ROW_W'(ROWS - 1);
        wr_ptr  <= ROW_W'(ROWS - 1);
        cnt     <= '0;
      end else if (walking) begin
        // kept rows move the write pointer, full rows only count
        if (row_full) begin
          cnt <= cnt + ROW_W'(1);
        end else begin
          wr_ptr <= wr_ptr - ROW_W'(1);
        end
        if (rd_ptr == '0) begin
          walking <= 1'b0;
          filling <= 1'b1;
        end else begin
          rd_ptr <= rd_ptr - ROW_W'(1);
        end
      end else if (filling) begin
        filling  <= 1'b0;
        clr.done <= 1'b1;
        lines    <= lines + LINES_W'(clr.full_rows);
      end
      // game restart from the engine
      if (clr.restart) begin
        lines <= '0;
      end
    end
  end

  // grid data path
  always_ff @(posedge clk) begin
    if (clr.start && !busy) begin
      src <= clr.grid_in;
    end
    if (walking && !row_full) begin
      dst[wr_ptr] <= src[rd_ptr];
    end
    if (filling) begin
      // one empty row on top per removed row
      for (int r = 0; r < ROWS; r++) begin
        if (r < int'(cnt)) begin
          dst[r] <= '0;
        end
      end
    end
  end

endmodule

// ==== rtl/piece_engine.sv ====
`timescale 1ns/100ps

module piece_engine (
  input  logic           clk,
  input  logic           rst,
  input  logic           en,
  input  logic           move_valid,
  input  logic [1:0]     move,
  clear_if.engine_mp     clr,
  output logic [tetris_pkg::ROWS-1:0][tetris_pkg::COLS-1:0][tetris_pkg::CELL_W-1:0] grid,
  output logic           ready,
  output logic           game_over,
  output logic           lock
);
  import tetris_pkg::*;

  logic [2:0] state;

  // active piece
  logic [ROW_W-1:0]   row;
  logic [COL_W-1:0]   col;
  logic [SHAPE_W-1:0] piece_shape;
  logic [CELL_W-1:0]  color;

  // next shape to spawn
  logic [SHAPE_W-1:0] shape_cnt;
  logic [SHAPE_W-1:0] shape_nxt;
  logic [CELL_W-1:0]  spawn_color;

  piece_mask_u cur_mask;
  piece_mask_u spawn_mask;

  // grid with the active piece lifted out
  logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] base;
  logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] moved_grid;
  logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] spawn_grid;

  int   tgt_row;
  int   tgt_col;
  logic move_ok;
  logic spawn_ok;

  ////////////////////
  // frame helpers
  ////////////////////

  // every set frame cell must land inside the grid on an empty cell
  function automatic logic fits(
    input logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] g,
    input piece_mask_u m,
    input int r0,
    input int c0
  );
    logic ok;
    int   r;
    int   c;
    // an empty frame never counts as a fit
    ok = (m.flat != 16'h0000);
    for (int fr = 0; fr < 4; fr++) begin
      for (int fc = 0; fc < 4; fc++) begin
        if (m.rows[fr][fc]) begin
          r = r0 + fr;
          c = c0 + fc;
          if (r < 0 || r >= ROWS || c < 0 || c >= COLS) begin
            ok = 1'b0;
          end else if (g[r[ROW_W-1:0]][c[COL_W-1:0]] != '0) begin
            ok = 1'b0;
          end
        end
      end
    end
    return ok;
  endfunction

  // paint the set frame cells with one color, 0 erases
  function automatic logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] draw(
    input logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] g,
    input piece_mask_u m,
    input int r0,
    input int c0,
    input logic [CELL_W-1:0] cl
  );
    logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] res;
    int r;
    int c;
    res = g;
    for (int fr = 0; fr < 4; fr++) begin
      for (int fc = 0; fc < 4; fc++) begin
        r = r0 + fr;
        c = c0 + fc;
        if (m.rows[fr][fc] && r >= 0 && r < ROWS && c >= 0 && c < COLS) begin
          res[r[ROW_W-1:0]][c[COL_W-1:0]] = cl;
        end
      end
    end
    return res;
  endfunction

  ////////////////////
  // next position
  ////////////////////

  assign shape_nxt   = (shape_cnt == SHAPE_W'(NUM_SHAPES - 1)) ? '0 : shape_cnt + SHAPE_W'(1);
  assign spawn_color = CELL_W'(shape_cnt) + CELL_W'(1);

  always_comb begin
    cur_mask.flat   = SHAPE_MASKS[piece_shape];
    spawn_mask.flat = SHAPE_MASKS[shape_cnt];
    tgt_row = int'(row);
    tgt_col = int'(col);
    case (move)
      MV_RIGHT: tgt_col = int'(col) + 1;
      MV_LEFT:  tgt_col = int'(col) - 1;
      MV_DOWN:  tgt_row = int'(row) + 1;
      default:  tgt_row = int'(row);
    endcase
    // move checked against the grid without the piece itself
    base       = draw(grid, cur_mask, int'(row), int'(col), '0);
    move_ok    = fits(base, cur_mask, tgt_row, tgt_col);
    moved_grid = draw(base, cur_mask, tgt_row, tgt_col, color);
    // spawn checked against the settled stack
    spawn_ok   = fits(grid, spawn_mask, SPAWN_ROW, SPAWN_COL);
    spawn_grid = draw(grid, spawn_mask, SPAWN_ROW, SPAWN_COL, spawn_color);
  end

  assign ready       = (state == ST_PLAY);
  assign game_over   = (state == ST_OVER);
  assign clr.grid_in = grid;

  ////////////////////
  // game fsm
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= ST_IDLE;
      grid        <= '0;
      row         <= '0;
      col         <= '0;
      piece_shape <= '0;
      color       <= '0;
      shape_cnt   <= '0;
      lock        <= 1'b0;
      clr.start   <= 1'b0;
      clr.restart <= 1'b0;
    end else begin
      // strobes default low
      lock        <= 1'b0;
      clr.start   <= 1'b0;
      clr.restart <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (en) begin
            state <= ST_SPAWN;
          end
        end
        ST_SPAWN: begin
          if (spawn_ok) begin
            grid        <= spawn_grid;
            row         <= ROW_W'(SPAWN_ROW);
            col         <= COL_W'(SPAWN_COL);
            piece_shape <= shape_cnt;
            color       <= spawn_color;
            shape_cnt   <= shape_nxt;
            state       <= ST_PLAY;
          end else begin
            state <= ST_OVER;
          end
        end
        ST_PLAY: begin
          if (move_valid) begin
            if (move_ok) begin
              grid <= moved_grid;
              row  <= tgt_row[ROW_W-1:0];
              col  <= tgt_col[COL_W-1:0];
            end else if (move == MV_DOWN) begin
              // piece stays in the grid as it is, hand it to line_clear
              lock      <= 1'b1;
              clr.start <= 1'b1;
              state     <= ST_CLEAR;
            end
          end
        end
        ST_CLEAR: begin
          if (clr.done) begin
            grid  <= clr.grid_out;
            state <= ST_SPAWN;
          end
        end
        ST_OVER: begin
          if (en) begin
            grid        <= '0;
            shape_cnt   <= '0;
            clr.restart <= 1'b1;
            state       <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/move_arbiter.sv ====
`timescale 1ns/100ps

module move_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic       right,
  input  logic       left,
  input  logic       down,
  output logic       move_valid,
  output logic [1:0] move
);
  import tetris_pkg::*;

  // button levels from the previous edge
  logic right_q;
  logic left_q;
  logic down_q;

  // rising edges this cycle
  logic rise_right;
  logic rise_left;
  logic rise_down;

  // picked command before the register
  logic [1:0] pick;

  assign rise_right = right & ~right_q;
  assign rise_left  = left & ~left_q;
  assign rise_down  = down & ~down_q;

  ////////////////////
  // fixed priority
  ////////////////////

  // right beats left, left beats down
  always_comb begin
    if (rise_right) begin
      pick = MV_RIGHT;
    end else if (rise_left) begin
      pick = MV_LEFT;
    end else if (rise_down) begin
      pick = MV_DOWN;
    end else begin
      pick = MV_NONE;
    end
  end

  // strobe and code leave together, one cycle after the edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      right_q    <= 1'b0;
      left_q     <= 1'b0;
      down_q     <= 1'b0;
      move_valid <= 1'b0;
      move       <= MV_NONE;
    end else begin
      right_q    <= right;
      left_q     <= left;
      down_q     <= down;
      move_valid <= rise_right | rise_left | rise_down;
      move       <= pick;
    end
  end

endmodule

// ==== rtl/clear_if.sv ====
`timescale 1ns/100ps

interface clear_if;
  import tetris_pkg::*;

  // engine side, start only while no pass runs
  logic start;
  logic restart;
  logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] grid_in;

  // clear side, grid_out and full_rows valid with done
  logic done;
  logic [ROWS-1:0][COLS-1:0][CELL_W-1:0] grid_out;
  logic [ROW_W-1:0] full_rows;

  modport engine_mp (
    output start, restart, grid_in,
    input  done, grid_out, full_rows
  );

  modport clear_mp (
    input  start, restart, grid_in,
    output done, grid_out, full_rows
  );

endinterface

// ==== rtl/tetris_pkg.sv ====
package tetris_pkg;

  ////////////////////
  // grid geometry
  ////////////////////

  // row 0 is the top, cell value 0 is empty
  localparam int ROWS   = 22;
  localparam int COLS   = 10;
  localparam int CELL_W = 3;

  // coordinate widths for the piece anchor
  localparam int ROW_W = 5;
  localparam int COL_W = 4;

  // width of the cleared-line counter
  localparam int LINES_W = 16;

  // top-left corner of the 4x4 frame at spawn
  localparam int SPAWN_ROW = 0;
  localparam int SPAWN_COL = 3;

  ////////////////////
  // shapes
  ////////////////////

  localparam int NUM_SHAPES = 7;
  localparam int SHAPE_W    = 3;

  // frame row r in bits 4r+3:4r, bit c is frame column c
  localparam logic [15:0] SHAPE_MASKS [NUM_SHAPES] = '{
    16'h000F,  // I
    16'h0066,  // O
    16'h0027,  // T
    16'h0036,  // S
    16'h0063,  // Z
    16'h0071,  // J
    16'h0074   // L
  };

  // one mask word, read whole or as four frame rows
  typedef union packed {
    logic [15:0]     flat;
    logic [3:0][3:0] rows;
  } piece_mask_u;

  ////////////////////
  // codes
  ////////////////////

  // move commands
  localparam logic [1:0] MV_NONE  = 2'd0;
  localparam logic [1:0] MV_RIGHT = 2'd1;
  localparam logic [1:0] MV_LEFT  = 2'd2;
  localparam logic [1:0] MV_DOWN  = 2'd3;

  // engine states
  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_SPAWN = 3'd1;
  localparam logic [2:0] ST_PLAY  = 3'd2;
  localparam logic [2:0] ST_CLEAR = 3'd3;
  localparam logic [2:0] ST_OVER  = 3'd4;

endpackage
